// File: compile.f
mips_isa_pkg.sv
mips_pipe_pkg.sv
mips_fetch.sv
mips_decode.sv
mips_register_file.sv
mips_execute.sv
mips_writeback.sv
mips_hazard_unit.sv
mips_cpu_harvard.sv
tb_mips_checker.sv
tb_mips_cpu.sv

// File: Makefile
# Verilator build and run of the pipelined MIPS core testbench

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_mips_cpu -f compile.f -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	@if grep -q "Test failed" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: compile run clean

// File: tb_mips_cpu.sv
// Testbench top: clock, reset, memories, random programs,
// clock-enable stimulus and watchdog
`timescale 1ns/1ns

module tb_mips_cpu
	import mips_isa_pkg::*;
();

	localparam int NUM_TESTS = 6;
	localparam int MEM_WORDS = 64;

	logic  clk = 1'b0;
	logic  rst;
	logic  clk_enable;
	logic  active;
	word_t register_v0;
	word_t instr_address;
	word_t instr_readdata;
	word_t data_address;
	logic  data_write;
	logic  data_read;
	word_t data_writedata;
	word_t data_readdata;

	word_t       imem [0:MEM_WORDS-1];
	word_t       dmem [0:MEM_WORDS-1];
	word_t       imem_offset;
	logic [31:0] prog_rng;
	// Separate stream for the enable
	logic [31:0] enable_rng = 32'd97901 ^ 32'h9E3779B9;
	int          lengths [NUM_TESTS];
	int          budget_cycles = 0;

	always #4 clk = ~clk;

	mips_cpu_harvard u_mips_cpu_harvard (
		.clk(clk), .rst(rst), .clk_enable(clk_enable), .active(active),
		.register_v0(register_v0), .instr_address(instr_address),
		.instr_readdata(instr_readdata), .data_address(data_address),
		.data_write(data_write), .data_read(data_read),
		.data_writedata(data_writedata), .data_readdata(data_readdata)
	);

	tb_mips_checker u_checker (
		.clk(clk), .rst(rst), .clk_enable(clk_enable), .active(active),
		.register_v0(register_v0), .instr_address(instr_address),
		.data_write(data_write), .data_read(data_read),
		.data_address(data_address), .data_writedata(data_writedata)
	);

	// Fetch outside the image sees a NOP
	assign imem_offset    = instr_address - RESET_VECTOR;
	assign instr_readdata = (imem_offset < 32'd256) ? imem[imem_offset[7:2]] : '0;
	assign data_readdata  = dmem[data_address[7:2]];

	always @(posedge clk) begin
		if (clk_enable && data_write)
			dmem[data_address[7:2]] <= data_writedata;
	end

	always @(posedge clk) begin
		enable_rng = xorshift(enable_rng);
		clk_enable <= enable_rng % 10 < 8;
	end

	function automatic logic [31:0] xorshift(logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic int rand_below(int n);
		prog_rng = xorshift(prog_rng);
		return int'(prog_rng % n);
	endfunction

	function automatic word_t rtype(logic [5:0] funct, int rs, int rt, int rd);
		return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, funct};
	endfunction

	function automatic word_t itype(logic [5:0] op, int rs, int rt, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	// Loads and stores use $0 as base inside the 64-word region
	function automatic word_t plain_instr();
		int kind;
		int rs;
		int rt;
		int rd;
		kind = rand_below(16);
		rs = rand_below(8);
		rt = rand_below(8);
		rd = rand_below(8);
		case (kind)
			0: return rtype(FN_ADDU, rs, rt, rd);
			1: return rtype(FN_SUBU, rs, rt, rd);
			2: return rtype(FN_AND, rs, rt, rd);
			3: return rtype(FN_OR, rs, rt, rd);
			4: return rtype(FN_XOR, rs, rt, rd);
			5: return rtype(FN_SLT, rs, rt, rd);
			6: return rtype(FN_SLTU, rs, rt, rd);
			7: return itype(OP_ADDIU, rs, rt, 16'(rand_below(65536)));
			8: return itype(OP_ANDI, rs, rt, 16'(rand_below(65536)));
			9: return itype(OP_ORI, rs, rt, 16'(rand_below(65536)));
			10: return itype(OP_XORI, rs, rt, 16'(rand_below(65536)));
			11: return itype(OP_LUI, 0, rt, 16'(rand_below(65536)));
			12, 13: return itype(OP_LW, 0, rt, 16'(4 * rand_below(MEM_WORDS)));
			default: return itype(OP_SW, 0, rt, 16'(4 * rand_below(MEM_WORDS)));
		endcase
	endfunction

	// Forward branches only, never in a delay slot, never past the final JR
	task automatic build_program(int len);
		int tgt;
		int kind;
		bit prev_ctrl;
		prev_ctrl = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++)
			imem[i] = '0;
		for (int i = 0; i < len - 2; i++) begin
			if (i <= len - 4 && !prev_ctrl && rand_below(4) == 0) begin
				tgt = i + 2 + rand_below(len - 3 - i);
				kind = rand_below(3);
				if (kind == 2)
					imem[i] = {OP_J, 26'((RESET_VECTOR + 32'(4 * tgt)) >> 2)};
				else
					imem[i] = itype(kind == 1 ? OP_BNE : OP_BEQ, rand_below(8), rand_below(8),
					                16'(tgt - i - 1));
				prev_ctrl = 1'b1;
			end else begin
				imem[i] = plain_instr();
				prev_ctrl = 1'b0;
			end
		end
		imem[len - 2] = rtype(FN_JR, 0, 0, 0);
		imem[len - 1] = plain_instr();
	endtask

	function automatic word_t fill_word(int idx);
		logic [7:0] addr;
		addr = 8'(idx * 4);
		return {addr, ~addr, addr ^ 8'h5A, 8'hC3};
	endfunction

	initial begin
		int drained;
		int total;
		rst <= 1'b1;
		clk_enable <= 1'b0;
		prog_rng = 32'd97901;
		total = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			lengths[t] = 20 + rand_below(21);
			total += lengths[t];
		end
		// Reset and drain of each program come on top
		budget_cycles = total * 20 + NUM_TESTS * 40;
		for (int t = 0; t < NUM_TESTS; t++) begin
			build_program(lengths[t]);
			for (int k = 0; k < MEM_WORDS; k++) begin
				dmem[k] <= fill_word(k);
				u_checker.load_image_word(k, imem[k], fill_word(k));
			end
			u_checker.start_test(t, lengths[t]);
			if (t > 0) begin
				@(posedge clk);
				rst <= 1'b1;
			end
			repeat (2) @(posedge clk);
			rst <= 1'b0;
			@(negedge clk);
			u_checker.check_reset();
			while (active)
				@(negedge clk);
			// Delay slot and older instructions leave the pipeline
			drained = 0;
			while (drained < 8) begin
				@(posedge clk);
				if (clk_enable)
					drained++;
			end
			@(negedge clk);
			u_checker.finish_test();
		end
		$display("%0d programs run, %0d with errors, %0d errors in total",
		         u_checker.tests_run, u_checker.tests_bad, u_checker.error_count);
		if (u_checker.error_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		wait (budget_cycles > 0);
		repeat (budget_cycles) @(posedge clk);
		$display("Timeout: programs not finished after %0d cycles", budget_cycles);
		$display("Test failed");
		$finish;
	end

endmodule

// File: tb_mips_checker.sv
// ISA reference model with delay slots, data-write and register_v0
// comparison, per-program report
`timescale 1ns/1ns

module tb_mips_checker
	import mips_isa_pkg::*;
(
	input logic  clk,
	input logic  rst,
	input logic  clk_enable,
	input logic  active,
	input word_t register_v0,
	input word_t instr_address,
	input logic  data_write,
	input logic  data_read,
	input word_t data_address,
	input word_t data_writedata
);

	word_t prog [0:63];
	word_t mem [0:63];
	word_t regs [0:31];
	word_t exp_addr [$];
	word_t exp_data [$];
	word_t exp_v0;
	int    test_num;
	int    test_len;
	int    test_errors;
	int    write_count;
	int    error_count = 0;
	int    tests_run = 0;
	int    tests_bad = 0;
	logic  halted_seen;

	task automatic report_mismatch(string name, word_t got, word_t exp);
		$display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
		test_errors++;
		error_count++;
	endtask

	task automatic report_error(string msg);
		$display("Error at %0t: %s", $time, msg);
		test_errors++;
		error_count++;
	endtask

	task automatic load_image_word(int idx, word_t instr, word_t data);
		prog[idx] = instr;
		mem[idx] = data;
	endtask

	task automatic set_reg(logic [4:0] idx, word_t value);
		if (idx != 5'd0)
			regs[idx] = value;
	endtask

	// Runs the whole program up front and queues the expected stores
	task automatic start_test(int num, int len);
		word_t pc;
		word_t npc;
		word_t next;
		word_t ins;
		word_t a;
		word_t b;
		word_t imm_s;
		word_t addr;
		int    steps;
		test_num = num;
		test_len = len;
		test_errors = 0;
		write_count = 0;
		exp_addr.delete();
		exp_data.delete();
		for (int r = 0; r < 32; r++)
			regs[r] = '0;
		pc = RESET_VECTOR;
		npc = RESET_VECTOR + 32'd4;
		steps = 0;
		while (pc != '0 && steps < 4 * len) begin
			ins = prog[pc[7:2]];
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			imm_s = {{16{ins[15]}}, ins[15:0]};
			addr = a + imm_s;
			next = npc + 32'd4;
			case (ins[31:26])
				OP_RTYPE: begin
					case (ins[5:0])
						FN_ADDU: set_reg(ins[15:11], a + b);
						FN_SUBU: set_reg(ins[15:11], a - b);
						FN_AND:  set_reg(ins[15:11], a & b);
						FN_OR:   set_reg(ins[15:11], a | b);
						FN_XOR:  set_reg(ins[15:11], a ^ b);
						FN_SLT:  set_reg(ins[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
						FN_SLTU: set_reg(ins[15:11], (a < b) ? 32'd1 : 32'd0);
						FN_JR:   next = a;
						default: ;
					endcase
				end
				OP_ADDIU: set_reg(ins[20:16], addr);
				OP_ANDI:  set_reg(ins[20:16], a & {16'h0, ins[15:0]});
				OP_ORI:   set_reg(ins[20:16], a | {16'h0, ins[15:0]});
				OP_XORI:  set_reg(ins[20:16], a ^ {16'h0, ins[15:0]});
				OP_LUI:   set_reg(ins[20:16], {ins[15:0], 16'h0});
				OP_LW:    set_reg(ins[20:16], mem[addr[7:2]]);
				OP_SW: begin
					mem[addr[7:2]] = b;
					exp_addr.push_back(addr);
					exp_data.push_back(b);
				end
				OP_BEQ: if (a == b) next = npc + (imm_s << 2);
				OP_BNE: if (a != b) next = npc + (imm_s << 2);
				OP_J:   next = {npc[31:28], ins[25:0], 2'b00};
				default: ;
			endcase
			// Delay slot runs before the target
			pc = npc;
			npc = next;
			steps++;
		end
		if (pc != '0)
			report_error($sformatf("model never reached the halt of program %0d", num));
		exp_v0 = regs[REG_V0];
	endtask

	task automatic check_reset();
		if (active !== 1'b1)
			report_mismatch("active", {31'b0, active}, 32'd1);
		if (instr_address !== RESET_VECTOR)
			report_mismatch("instr_address", instr_address, RESET_VECTOR);
		if (data_write !== 1'b0)
			report_mismatch("data_write", {31'b0, data_write}, 32'd0);
		if (data_read !== 1'b0)
			report_mismatch("data_read", {31'b0, data_read}, 32'd0);
	endtask

	task automatic finish_test();
		if (exp_addr.size() != 0)
			report_error($sformatf("%0d expected data writes never happened", exp_addr.size()));
		if (register_v0 !== exp_v0)
			report_mismatch("register_v0", register_v0, exp_v0);
		if (active !== 1'b0)
			report_error("active still high after the program ended");
		tests_run++;
		if (test_errors != 0)
			tests_bad++;
		$display("program %0d: %0d instructions, %0d data writes, %0d errors",
		         test_num, test_len, write_count, test_errors);
	endtask

	// Only writes on an enabled edge reach memory
	always @(posedge clk) begin
		if (!rst && clk_enable && data_write) begin
			write_count++;
			if (exp_addr.size() == 0) begin
				report_error("data write after the last store of the program");
			end else begin
				if (data_address !== exp_addr[0])
					report_mismatch("data_address", data_address, exp_addr[0]);
				if (data_writedata !== exp_data[0])
					report_mismatch("data_writedata", data_writedata, exp_data[0]);
				void'(exp_addr.pop_front());
				void'(exp_data.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		if (rst)
			halted_seen <= 1'b0;
		else if (!active)
			halted_seen <= 1'b1;
		else if (halted_seen)
			report_error("active rose again after the halt");
	end

endmodule

// File: mips_cpu_harvard.sv
// Pipelined MIPS32 core, Harvard bus
// Stages, register file and hazard unit wired to the ports
`timescale 1ns/1ns

module mips_cpu_harvard
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;
#(
	parameter word_t RESET_ADDR = RESET_VECTOR
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  clk_enable,
	output logic  active,
	output word_t register_v0,

	output word_t instr_address,
	input  word_t instr_readdata,

	output word_t data_address,
	output logic  data_write,
	output logic  data_read,
	output word_t data_writedata,
	input  word_t data_readdata
);

	logic     stall;
	logic     flush_ex;
	logic     pc_redirect;
	word_t    pc_target;
	instr_t   instr_dec;
	word_t    pc_plus4_dec;
	reg_idx_t rs_dec;
	reg_idx_t rt_dec;
	ctrl_t    ctrl_dec;
	word_t    rd_data_a;
	word_t    rd_data_b;
	logic     fwd_a_dec;
	logic     fwd_b_dec;
	fwd_sel_e fwd_a_ex;
	fwd_sel_e fwd_b_ex;
	dec_ex_t  dec_ex;
	ex_mem_t  ex_mem;
	reg_idx_t write_reg_ex;
	logic     reg_write_wb;
	reg_idx_t write_reg_wb;
	word_t    result_wb;

	// Memory stage drives the data port directly
	assign data_address   = ex_mem.alu_out;
	assign data_writedata = ex_mem.write_data;
	assign data_write     = ex_mem.mem_write;
	assign data_read      = ex_mem.mem_to_reg;

	mips_fetch #(
		.RESET_ADDR(RESET_ADDR)
	) u_fetch (
		.clk(clk), .rst(rst), .clk_enable(clk_enable), .stall(stall),
		.pc_redirect(pc_redirect), .pc_target(pc_target),
		.instr_readdata(instr_readdata), .instr_address(instr_address),
		.instr_dec(instr_dec), .pc_plus4_dec(pc_plus4_dec), .active(active)
	);

	mips_decode u_decode (
		.clk(clk), .rst(rst), .clk_enable(clk_enable), .flush_ex(flush_ex),
		.instr_dec(instr_dec), .pc_plus4_dec(pc_plus4_dec),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
		.fwd_a_dec(fwd_a_dec), .fwd_b_dec(fwd_b_dec), .alu_out_mem(ex_mem.alu_out),
		.rs_dec(rs_dec), .rt_dec(rt_dec), .ctrl_dec(ctrl_dec),
		.pc_redirect(pc_redirect), .pc_target(pc_target), .dec_ex(dec_ex)
	);

	mips_register_file u_register_file (
		.clk(clk), .rst(rst), .clk_enable(clk_enable), .write_enable(reg_write_wb),
		.read_addr_a(rs_dec), .read_addr_b(rt_dec), .write_addr(write_reg_wb),
		.write_data(result_wb), .read_data_a(rd_data_a), .read_data_b(rd_data_b),
		.register_v0(register_v0)
	);

	mips_execute u_execute (
		.clk(clk), .rst(rst), .clk_enable(clk_enable), .dec_ex(dec_ex),
		.fwd_a_ex(fwd_a_ex), .fwd_b_ex(fwd_b_ex), .result_wb(result_wb),
		.ex_mem(ex_mem), .write_reg_ex(write_reg_ex)
	);

	mips_writeback u_writeback (
		.clk(clk), .rst(rst), .clk_enable(clk_enable), .ex_mem(ex_mem),
		.data_readdata(data_readdata), .reg_write_wb(reg_write_wb),
		.write_reg_wb(write_reg_wb), .result_wb(result_wb)
	);

	mips_hazard_unit u_hazard_unit (
		.rs_dec(rs_dec), .rt_dec(rt_dec), .ctrl_dec(ctrl_dec), .dec_ex(dec_ex),
		.write_reg_ex(write_reg_ex), .ex_mem(ex_mem), .reg_write_wb(reg_write_wb),
		.write_reg_wb(write_reg_wb), .stall(stall), .flush_ex(flush_ex),
		.fwd_a_dec(fwd_a_dec), .fwd_b_dec(fwd_b_dec),
		.fwd_a_ex(fwd_a_ex), .fwd_b_ex(fwd_b_ex)
	);

endmodule

// File: mips_hazard_unit.sv
// Stall, flush and forwarding decisions
`timescale 1ns/1ns

module mips_hazard_unit
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;
(
	input  reg_idx_t rs_dec,
	input  reg_idx_t rt_dec,
	input  ctrl_t    ctrl_dec,
	input  dec_ex_t  dec_ex,
	input  reg_idx_t write_reg_ex,
	input  ex_mem_t  ex_mem,
	input  logic     reg_write_wb,
	input  reg_idx_t write_reg_wb,
	output logic     stall,
	output logic     flush_ex,
	output logic     fwd_a_dec,
	output logic     fwd_b_dec,
	output fwd_sel_e fwd_a_ex,
	output fwd_sel_e fwd_b_ex
);

	logic rs_hit_ex, rt_hit_ex;
	logic rs_load_mem, rt_load_mem;
	logic load_use, branch_dep;

	function automatic logic writes(logic en, reg_idx_t dst, reg_idx_t src);
		return en && dst != '0 && dst == src;
	endfunction

	// Memory stage wins over writeback
	function automatic fwd_sel_e pick_ex(reg_idx_t src);
		if (writes(ex_mem.reg_write, ex_mem.write_reg, src))
			return FWD_MEM;
		if (writes(reg_write_wb, write_reg_wb, src))
			return FWD_WB;
		return FWD_NONE;
	endfunction

	assign rs_hit_ex   = writes(dec_ex.ctrl.reg_write, write_reg_ex, rs_dec);
	assign rt_hit_ex   = writes(dec_ex.ctrl.reg_write, write_reg_ex, rt_dec);
	assign rs_load_mem = writes(ex_mem.mem_to_reg, ex_mem.write_reg, rs_dec);
	assign rt_load_mem = writes(ex_mem.mem_to_reg, ex_mem.write_reg, rt_dec);

	assign load_use   = dec_ex.ctrl.mem_to_reg && (rs_hit_ex || rt_hit_ex);
	// JR compares nothing, only rs matters there
	assign branch_dep = (ctrl_dec.branch && (rs_hit_ex || rt_hit_ex ||
	                                         rs_load_mem || rt_load_mem)) ||
	                    (ctrl_dec.jump_reg && (rs_hit_ex || rs_load_mem));

	assign stall    = load_use || branch_dep;
	assign flush_ex = stall;

	assign fwd_a_dec = writes(ex_mem.reg_write, ex_mem.write_reg, rs_dec);
	assign fwd_b_dec = writes(ex_mem.reg_write, ex_mem.write_reg, rt_dec);
	assign fwd_a_ex  = pick_ex(dec_ex.rs);
	assign fwd_b_ex  = pick_ex(dec_ex.rt);

endmodule

// File: mips_writeback.sv
// Memory/writeback register and result select
`timescale 1ns/1ns

module mips_writeback
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     clk_enable,
	input  ex_mem_t  ex_mem,
	input  word_t    data_readdata,
	output logic     reg_write_wb,
	output reg_idx_t write_reg_wb,
	output word_t    result_wb
);

	mem_wb_t mem_wb;

	always_ff @(posedge clk) begin
		if (rst)
			mem_wb <= '0;
		else if (clk_enable)
			mem_wb <= '{reg_write: ex_mem.reg_write, mem_to_reg: ex_mem.mem_to_reg,
			            write_reg: ex_mem.write_reg, alu_out: ex_mem.alu_out,
			            read_data: data_readdata};
	end

	assign reg_write_wb = mem_wb.reg_write;
	assign write_reg_wb = mem_wb.write_reg;
	assign result_wb    = mem_wb.mem_to_reg ? mem_wb.read_data : mem_wb.alu_out;

endmodule

// File: mips_execute.sv
// Execute stage: forwarding muxes, ALU, destination select
// and the execute/memory register
`timescale 1ns/1ns

module mips_execute
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     clk_enable,
	input  dec_ex_t  dec_ex,
	input  fwd_sel_e fwd_a_ex,
	input  fwd_sel_e fwd_b_ex,
	input  word_t    result_wb,
	output ex_mem_t  ex_mem,
	output reg_idx_t write_reg_ex
);

	word_t op_a;
	word_t op_b;
	word_t op_b_alu;
	word_t imm_ext;
	word_t alu_out;

	function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t mem_val,
	                                  word_t wb_val);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB:  return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign op_a = fwd_mux(fwd_a_ex, dec_ex.src_a, ex_mem.alu_out, result_wb);
	assign op_b = fwd_mux(fwd_b_ex, dec_ex.src_b, ex_mem.alu_out, result_wb);

	assign imm_ext  = dec_ex.ctrl.zero_extend ? {16'b0, dec_ex.imm} :
	                                            {{16{dec_ex.imm[15]}}, dec_ex.imm};
	assign op_b_alu = dec_ex.ctrl.alu_src_imm ? imm_ext : op_b;

	always_comb begin
		case (dec_ex.ctrl.alu_op)
			ALU_ADD:  alu_out = op_a + op_b_alu;
			ALU_SUB:  alu_out = op_a - op_b_alu;
			ALU_AND:  alu_out = op_a & op_b_alu;
			ALU_OR:   alu_out = op_a | op_b_alu;
			ALU_XOR:  alu_out = op_a ^ op_b_alu;
			ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b_alu)};
			ALU_SLTU: alu_out = {31'b0, op_a < op_b_alu};
			default:  alu_out = {op_b_alu[15:0], 16'b0};
		endcase
	end

	assign write_reg_ex = dec_ex.ctrl.dest_rd ? dec_ex.rd : dec_ex.rt;

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_mem <= '0;
		end else if (clk_enable) begin
			ex_mem.reg_write  <= dec_ex.ctrl.reg_write;
			ex_mem.mem_to_reg <= dec_ex.ctrl.mem_to_reg;
			ex_mem.mem_write  <= dec_ex.ctrl.mem_write;
			ex_mem.write_reg  <= write_reg_ex;
			ex_mem.alu_out    <= alu_out;
			// Store data comes from the forwarded rt value
			ex_mem.write_data <= op_b;
		end
	end

endmodule

// File: mips_register_file.sv
// 32x32 register file, write-before-read bypass and v0 tap
`timescale 1ns/1ns

module mips_register_file
	import mips_isa_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     clk_enable,
	input  logic     write_enable,
	input  reg_idx_t read_addr_a,
	input  reg_idx_t read_addr_b,
	input  reg_idx_t write_addr,
	input  word_t    write_data,
	output word_t    read_data_a,
	output word_t    read_data_b,
	output word_t    register_v0
);

	word_t regs [31:1];

	function automatic word_t read_port(reg_idx_t addr);
		if (addr == '0)
			return '0;
		if (write_enable && write_addr == addr)
			return write_data;
		return regs[addr];
	endfunction

	assign read_data_a = read_port(read_addr_a);
	assign read_data_b = read_port(read_addr_b);
	assign register_v0 = regs[REG_V0];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (clk_enable && write_enable && write_addr != '0) begin
			regs[write_addr] <= write_data;
		end
	end

endmodule

// File: mips_decode.sv
// Control decoder, branch comparator, branch and jump targets,
// and the decode/execute register
`timescale 1ns/1ns

module mips_decode
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     clk_enable,
	input  logic     flush_ex,
	input  instr_t   instr_dec,
	input  word_t    pc_plus4_dec,
	input  word_t    rd_data_a,
	input  word_t    rd_data_b,
	input  logic     fwd_a_dec,
	input  logic     fwd_b_dec,
	input  word_t    alu_out_mem,
	output reg_idx_t rs_dec,
	output reg_idx_t rt_dec,
	output ctrl_t    ctrl_dec,
	output logic     pc_redirect,
	output word_t    pc_target,
	output dec_ex_t  dec_ex
);

	logic [15:0] imm;
	word_t       cmp_a;
	word_t       cmp_b;
	word_t       branch_target;
	word_t       jump_target;
	logic        taken;

	assign rs_dec = instr_dec.rs;
	assign rt_dec = instr_dec.rt;
	assign imm    = imm_of(instr_dec);

	always_comb begin
		ctrl_dec = '0;
		case (instr_dec.opcode)
			OP_RTYPE: begin
				ctrl_dec.reg_write = 1'b1;
				ctrl_dec.dest_rd   = 1'b1;
				case (instr_dec.funct)
					FN_ADDU: ctrl_dec.alu_op = ALU_ADD;
					FN_SUBU: ctrl_dec.alu_op = ALU_SUB;
					FN_AND:  ctrl_dec.alu_op = ALU_AND;
					FN_OR:   ctrl_dec.alu_op = ALU_OR;
					FN_XOR:  ctrl_dec.alu_op = ALU_XOR;
					FN_SLT:  ctrl_dec.alu_op = ALU_SLT;
					FN_SLTU: ctrl_dec.alu_op = ALU_SLTU;
					FN_JR: begin
						ctrl_dec.reg_write = 1'b0;
						ctrl_dec.jump_reg  = 1'b1;
					end
					default: ctrl_dec = '0;
				endcase
			end
			OP_ADDIU: {ctrl_dec.reg_write, ctrl_dec.alu_src_imm} = 2'b11;
			OP_ANDI, OP_ORI, OP_XORI: begin
				{ctrl_dec.reg_write, ctrl_dec.alu_src_imm, ctrl_dec.zero_extend} = 3'b111;
				ctrl_dec.alu_op = (instr_dec.opcode == OP_ANDI) ? ALU_AND :
				                  (instr_dec.opcode == OP_ORI)  ? ALU_OR  : ALU_XOR;
			end
			OP_LUI: begin
				{ctrl_dec.reg_write, ctrl_dec.alu_src_imm} = 2'b11;
				ctrl_dec.alu_op = ALU_LUI;
			end
			OP_LW: {ctrl_dec.reg_write, ctrl_dec.mem_to_reg, ctrl_dec.alu_src_imm} = 3'b111;
			OP_SW: {ctrl_dec.mem_write, ctrl_dec.alu_src_imm} = 2'b11;
			OP_BEQ: ctrl_dec.branch = 1'b1;
			OP_BNE: {ctrl_dec.branch, ctrl_dec.branch_ne} = 2'b11;
			OP_J:   ctrl_dec.jump = 1'b1;
			default: ctrl_dec = '0;
		endcase
	end

	// Comparator sees the memory-stage result early
	assign cmp_a = fwd_a_dec ? alu_out_mem : rd_data_a;
	assign cmp_b = fwd_b_dec ? alu_out_mem : rd_data_b;
	assign taken = ctrl_dec.branch && ((cmp_a == cmp_b) != ctrl_dec.branch_ne);

	assign branch_target = pc_plus4_dec + {{14{imm[15]}}, imm, 2'b00};
	assign jump_target   = {pc_plus4_dec[31:28], jump_index_of(instr_dec), 2'b00};
	assign pc_redirect   = taken || ctrl_dec.jump || ctrl_dec.jump_reg;
	assign pc_target     = ctrl_dec.jump_reg ? cmp_a :
	                       ctrl_dec.jump     ? jump_target : branch_target;

	always_ff @(posedge clk) begin
		if (rst) begin
			dec_ex <= '0;
		end else if (clk_enable) begin
			if (flush_ex)
				dec_ex <= '0;
			else
				dec_ex <= '{ctrl: ctrl_dec, rs: rs_dec, rt: rt_dec, rd: instr_dec.rd,
				            src_a: rd_data_a, src_b: rd_data_b, imm: imm};
		end
	end

endmodule

// File: mips_fetch.sv
// Program counter, next-PC select, halt latch and fetch/decode register
`timescale 1ns/1ns

module mips_fetch
	import mips_isa_pkg::*;
#(
	parameter word_t RESET_ADDR = RESET_VECTOR
) (
	input  logic   clk,
	input  logic   rst,
	input  logic   clk_enable,
	input  logic   stall,
	input  logic   pc_redirect,
	input  word_t  pc_target,
	input  word_t  instr_readdata,
	output word_t  instr_address,
	output instr_t instr_dec,
	output word_t  pc_plus4_dec,
	output logic   active
);

	word_t pc;
	word_t pc_plus4;
	word_t pc_next;
	logic  halted;

	assign pc_plus4      = pc + 32'd4;
	assign pc_next       = pc_redirect ? pc_target : pc_plus4;
	assign instr_address = pc;
	assign active        = !halted;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc           <= RESET_ADDR;
			halted       <= 1'b0;
			instr_dec    <= '0;
			pc_plus4_dec <= '0;
		end else if (clk_enable && !stall) begin
			if (!halted) begin
				pc <= pc_next;
				// Jump to address zero ends the program
				if (pc_next == '0)
					halted <= 1'b1;
			end
			// All-zero word is sll $0,$0,0
			instr_dec    <= halted ? '0 : instr_t'(instr_readdata);
			pc_plus4_dec <= pc_plus4;
		end
	end

endmodule

// File: mips_pipe_pkg.sv
// Pipeline-internal types: ALU operations, decoded control,
// stage registers and forwarding selects
package mips_pipe_pkg;

	import mips_isa_pkg::*;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_LUI
	} alu_op_e;

	// All zero is a bubble
	typedef struct packed {
		logic    reg_write;
		logic    mem_to_reg;
		logic    mem_write;
		logic    alu_src_imm;
		logic    zero_extend;
		logic    dest_rd;
		logic    branch;
		logic    branch_ne;
		logic    jump;
		logic    jump_reg;
		alu_op_e alu_op;
	} ctrl_t;

	typedef struct packed {
		ctrl_t       ctrl;
		reg_idx_t    rs;
		reg_idx_t    rt;
		reg_idx_t    rd;
		word_t       src_a;
		word_t       src_b;
		logic [15:0] imm;
	} dec_ex_t;

	typedef struct packed {
		logic     reg_write;
		logic     mem_to_reg;
		logic     mem_write;
		reg_idx_t write_reg;
		word_t    alu_out;
		word_t    write_data;
	} ex_mem_t;

	typedef struct packed {
		logic     reg_write;
		logic     mem_to_reg;
		reg_idx_t write_reg;
		word_t    alu_out;
		word_t    read_data;
	} mem_wb_t;

	typedef enum logic [1:0] {
		FWD_NONE,
		FWD_MEM,
		FWD_WB
	} fwd_sel_e;

endpackage

// File: mips_isa_pkg.sv
// MIPS32 architectural definitions: word and index types,
// primary opcodes, R-type function codes and the instruction layout
package mips_isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;

	// Kept primary opcodes, everything else decodes as a NOP
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDIU = 6'h09,
		OP_ANDI  = 6'h0C,
		OP_ORI   = 6'h0D,
		OP_XORI  = 6'h0E,
		OP_LUI   = 6'h0F,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2B
	} opcode_e;

	typedef enum logic [5:0] {
		FN_JR   = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2A,
		FN_SLTU = 6'h2B
	} funct_e;

	// R-type view; immediate is bits 15:0, jump index bits 25:0
	typedef struct packed {
		logic [5:0] opcode;
		reg_idx_t   rs;
		reg_idx_t   rt;
		reg_idx_t   rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instr_t;

	function automatic logic [15:0] imm_of(instr_t instr);
		return instr[15:0];
	endfunction

	function automatic logic [25:0] jump_index_of(instr_t instr);
		return instr[25:0];
	endfunction

	localparam word_t RESET_VECTOR = 32'hBFC00000;
	localparam reg_idx_t REG_V0 = 5'd2;

endpackage
